//--- src/st7789_pkg.sv
package st7789_pkg;

  typedef logic [7:0] byte_t;

  // Panel geometry
  localparam int X_SIZE     = 240;
  localparam int Y_SIZE     = 240;
  localparam int PIXELS     = X_SIZE * Y_SIZE;
  localparam int COLOR_BITS = 16;               // RGB565
  localparam int X_BITS     = $clog2(X_SIZE);
  localparam int Y_BITS     = $clog2(Y_SIZE);
  localparam int PIX_BITS   = $clog2(PIXELS);

  // Window end coordinates for CASET and RASET
  localparam logic [15:0] WIN_X_END = 16'(X_SIZE - 1);
  localparam logic [15:0] WIN_Y_END = 16'(Y_SIZE - 1);

  // ST7789 commands
  localparam byte_t CMD_CASET = 8'h2A;
  localparam byte_t CMD_RASET = 8'h2B;
  localparam byte_t CMD_RAMWR = 8'h2C;

  // Frame header is CASET + 4, RASET + 4, RAMWR
  localparam int HEADER_BYTES = 11;
  localparam int STEP_BITS    = $clog2(HEADER_BYTES);

  // Panel reset and init timing, in clk_pixel cycles
  localparam int RESET_HOLD_CYCLES = 64;
  localparam int RESET_WAIT_CYCLES = 256;
  localparam int DELAY_UNIT_CYCLES = 1024;
  localparam int TIMER_BITS        = $clog2(255 * DELAY_UNIT_CYCLES + 1);

  localparam int    INIT_WORDS     = 20;
  localparam int    INIT_ADDR_BITS = $clog2(INIT_WORDS + 1); // one past the end marks done
  localparam string INIT_FILE      = "st7789_init.mem";

  // Color bars
  localparam int BAR_WIDTH    = 30;
  localparam int BAR_COUNT    = 8;
  localparam int BAR_BITS     = $clog2(BAR_COUNT);
  localparam int BAR_POS_BITS = $clog2(BAR_WIDTH);

  localparam logic [BAR_COUNT-1:0][COLOR_BITS-1:0] BAR_COLORS = {
    16'h0000,  // black
    16'h001F,  // blue
    16'hF800,  // red
    16'hF81F,  // magenta
    16'h07E0,  // green
    16'h07FF,  // cyan
    16'hFFE0,  // yellow
    16'hFFFF   // white, leftmost bar
  };

  // Init sequencer phases
  localparam logic [1:0] SEQ_HOLD = 2'd0;
  localparam logic [1:0] SEQ_WAIT = 2'd1;
  localparam logic [1:0] SEQ_ROM  = 2'd2;
  localparam logic [1:0] SEQ_DONE = 2'd3;

  // Frame sequencer states
  localparam logic [1:0] FRM_SYNC   = 2'd0;
  localparam logic [1:0] FRM_HEADER = 2'd1;
  localparam logic [1:0] FRM_PIX_HI = 2'd2;
  localparam logic [1:0] FRM_PIX_LO = 2'd3;

  // Init ROM word, bit 9 selects which view applies
  typedef union packed {
    struct packed {
      logic  is_delay;
      logic  dc;
      byte_t data;
    } spi_item;
    struct packed {
      logic       is_delay;
      logic       rsvd;
      logic [7:0] count;      // in DELAY_UNIT_CYCLES
    } pause;
  } init_word_t;

endpackage

//--- src/pattern_gen.sv
`timescale 1ns/10ps

module pattern_gen
  import st7789_pkg::*;
(
  input  logic                  clk_pixel,
  input  logic                  rst,
  input  logic                  pixel_next,
  output logic [COLOR_BITS-1:0] color,
  output logic                  frame_first
);

  logic [X_BITS-1:0]       x;
  logic [Y_BITS-1:0]       y;
  logic [BAR_BITS-1:0]     bar;      // x / BAR_WIDTH
  logic [BAR_POS_BITS-1:0] bar_pos;  // x mod BAR_WIDTH
  logic                    last_x;
  logic                    last_y;

  assign last_x = (x == X_BITS'(X_SIZE - 1));
  assign last_y = (y == Y_BITS'(Y_SIZE - 1));

  // Column position, tracked with the bar index so no divider is needed
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      x       <= '0;
      bar     <= '0;
      bar_pos <= '0;
    end else if (pixel_next) begin
      if (last_x) begin
        x       <= '0;
        bar     <= '0;
        bar_pos <= '0;
      end else begin
        x <= x + 1'b1;
        if (bar_pos == BAR_POS_BITS'(BAR_WIDTH - 1)) begin
          bar_pos <= '0;
          bar     <= bar + 1'b1;
        end else begin
          bar_pos <= bar_pos + 1'b1;
        end
      end
    end
  end

  // Row position
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      y <= '0;
    end else if (pixel_next && last_x) begin
      if (last_y) begin
        y <= '0;
      end else begin
        y <= y + 1'b1;
      end
    end
  end

  assign color       = BAR_COLORS[bar];  // Same bars on every row
  assign frame_first = (x == '0) && (y == '0);

endmodule

//--- src/lcd_init_seq.sv
`timescale 1ns/10ps

module lcd_init_seq
  import st7789_pkg::*;
(
  input  logic  clk_pixel,
  input  logic  rst,
  input  logic  init_ready,
  output logic  init_valid,
  output byte_t init_byte,
  output logic  init_dc,
  output logic  init_done,
  output logic  spi_resn
);

  init_word_t rom [INIT_WORDS];

  initial begin
    $readmemh(INIT_FILE, rom);
  end

  logic [1:0]                state;
  logic [INIT_ADDR_BITS-1:0] addr;
  logic [TIMER_BITS-1:0]     timer;   // Reset hold, reset wait and delay words
  logic                      rom_end;
  init_word_t                word;

  assign rom_end = (addr == INIT_ADDR_BITS'(INIT_WORDS));
  assign word    = rom_end ? '0 : rom[addr];

  // Byte words are offered only once any delay has run out
  assign init_valid = (state == SEQ_ROM) && (timer == '0) && !rom_end &&
                      !word.spi_item.is_delay;
  assign init_byte  = word.spi_item.data;
  assign init_dc    = word.spi_item.dc;

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      state     <= SEQ_HOLD;
      timer     <= TIMER_BITS'(RESET_HOLD_CYCLES - 1);
      addr      <= '0;
      spi_resn  <= 1'b0;
      init_done <= 1'b0;
    end else begin
      case (state)
        SEQ_HOLD: begin
          if (timer == '0) begin
            spi_resn <= 1'b1;                          // Release panel reset
            timer    <= TIMER_BITS'(RESET_WAIT_CYCLES - 1);
            state    <= SEQ_WAIT;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        SEQ_WAIT: begin
          if (timer == '0) begin
            state <= SEQ_ROM;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        SEQ_ROM: begin
          if (timer != '0) begin
            timer <= timer - 1'b1;                     // Delay word running
          end else if (rom_end) begin
            init_done <= 1'b1;
            state     <= SEQ_DONE;
          end else if (word.pause.is_delay) begin
            timer <= TIMER_BITS'(word.pause.count * DELAY_UNIT_CYCLES);
            addr  <= addr + 1'b1;
          end else if (init_ready) begin
            addr <= addr + 1'b1;                       // Byte taken by serializer
          end
        end
        default: begin
          // Done, init_done stays high until reset
        end
      endcase
    end
  end

endmodule

//--- src/lcd_spi_out.sv
`timescale 1ns/10ps

module lcd_spi_out
  import st7789_pkg::*;
(
  input  logic                  clk_pixel,
  input  logic                  rst,
  input  logic                  init_valid,
  input  byte_t                 init_byte,
  input  logic                  init_dc,
  input  logic                  init_done,
  input  logic [COLOR_BITS-1:0] color,
  input  logic                  frame_first,
  output logic                  init_ready,
  output logic                  pixel_next,
  output logic                  spi_clk,
  output logic                  spi_mosi,
  output logic                  spi_dc
);

  // Serializer
  logic       busy;
  logic [3:0] cnt;     // Bit index and clock phase
  byte_t      sh;
  logic       load_ok;
  logic       fire;

  // Byte source
  logic  src_valid;
  byte_t src_byte;
  logic  src_dc;

  // Frame sequencer
  logic [1:0]           frm_state;
  logic [STEP_BITS-1:0] step;
  logic [PIX_BITS-1:0]  pix_cnt;
  byte_t                lo_buf;
  byte_t                hdr_byte;
  logic                 hdr_dc;

  // Window header bytes, start coordinates are zero
  always_comb begin
    hdr_dc   = 1'b1;
    hdr_byte = '0;
    case (step)
      0: begin
        hdr_dc   = 1'b0;
        hdr_byte = CMD_CASET;
      end
      3:  hdr_byte = WIN_X_END[15:8];
      4:  hdr_byte = WIN_X_END[7:0];
      5: begin
        hdr_dc   = 1'b0;
        hdr_byte = CMD_RASET;
      end
      8:  hdr_byte = WIN_Y_END[15:8];
      9:  hdr_byte = WIN_Y_END[7:0];
      10: begin
        hdr_dc   = 1'b0;
        hdr_byte = CMD_RAMWR;
      end
      default: ;
    endcase
  end

  // Init bytes until init_done, frame traffic afterwards
  always_comb begin
    src_valid = init_valid;
    src_byte  = init_byte;
    src_dc    = init_dc;
    if (init_done) begin
      case (frm_state)
        FRM_HEADER: begin
          src_valid = 1'b1;
          src_byte  = hdr_byte;
          src_dc    = hdr_dc;
        end
        FRM_PIX_HI: begin
          src_valid = 1'b1;
          src_byte  = color[15:8];
          src_dc    = 1'b1;
        end
        FRM_PIX_LO: begin
          src_valid = 1'b1;
          src_byte  = lo_buf;
          src_dc    = 1'b1;
        end
        default: begin
          src_valid = 1'b0;  // Waiting for frame_first
          src_byte  = '0;
          src_dc    = 1'b0;
        end
      endcase
    end
  end

  assign load_ok    = !busy || (cnt == 4'd15);  // Last phase of the current byte
  assign fire       = src_valid && load_ok;
  assign init_ready = !init_done && init_valid && load_ok;

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      frm_state  <= FRM_SYNC;
      step       <= '0;
      pix_cnt    <= '0;
      pixel_next <= 1'b0;
    end else begin
      pixel_next <= 1'b0;
      if (init_done) begin
        case (frm_state)
          FRM_SYNC: begin
            if (frame_first) begin
              frm_state <= FRM_HEADER;
              step      <= '0;
            end
          end
          FRM_HEADER: begin
            if (fire) begin
              if (step == STEP_BITS'(HEADER_BYTES - 1)) begin
                frm_state <= FRM_PIX_HI;
                pix_cnt   <= '0;
              end else begin
                step <= step + 1'b1;
              end
            end
          end
          FRM_PIX_HI: begin
            if (fire) begin
              frm_state  <= FRM_PIX_LO;
              pixel_next <= 1'b1;  // Color is in the shifter and lo_buf now
            end
          end
          default: begin
            if (fire) begin
              if (pix_cnt == PIX_BITS'(PIXELS - 1)) begin
                frm_state <= FRM_SYNC;
              end else begin
                pix_cnt   <= pix_cnt + 1'b1;
                frm_state <= FRM_PIX_HI;
              end
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (init_done && (frm_state == FRM_PIX_HI) && fire) begin
      lo_buf <= color[7:0];
    end
  end

  // SPI mode 3, mosi moves on the falling edge
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      busy    <= 1'b0;
      cnt     <= '0;
      sh      <= '0;
      spi_clk <= 1'b1;
      spi_dc  <= 1'b0;
    end else if (fire) begin
      busy    <= 1'b1;
      cnt     <= '0;
      sh      <= src_byte;
      spi_dc  <= src_dc;
      spi_clk <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == 4'd15) begin
        busy <= 1'b0;            // spi_clk is already high
      end else begin
        spi_clk <= ~spi_clk;
        if (cnt[0]) begin
          sh <= {sh[6:0], 1'b0};
        end
      end
    end
  end

  assign spi_mosi = sh[7];

endmodule

//--- src/st7789_video_top.sv
`timescale 1ns/10ps

module st7789_video_top
  import st7789_pkg::*;
(
  input  logic clk_pixel,
  input  logic rst,
  output logic spi_clk,
  output logic spi_mosi,
  output logic spi_dc,
  output logic spi_resn
);

  logic                  init_valid;
  logic                  init_ready;
  byte_t                 init_byte;
  logic                  init_dc;
  logic                  init_done;
  logic                  pixel_next;
  logic [COLOR_BITS-1:0] color;
  logic                  frame_first;

  // Test picture source
  pattern_gen pattern_gen_inst (
    .clk_pixel   (clk_pixel),
    .rst         (rst),
    .pixel_next  (pixel_next),
    .color       (color),
    .frame_first (frame_first)
  );

  lcd_init_seq lcd_init_seq_inst (
    .clk_pixel  (clk_pixel),
    .rst        (rst),
    .init_ready (init_ready),
    .init_valid (init_valid),
    .init_byte  (init_byte),
    .init_dc    (init_dc),
    .init_done  (init_done),
    .spi_resn   (spi_resn)
  );

  lcd_spi_out lcd_spi_out_inst (
    .clk_pixel   (clk_pixel),
    .rst         (rst),
    .init_valid  (init_valid),
    .init_byte   (init_byte),
    .init_dc     (init_dc),
    .init_done   (init_done),
    .color       (color),
    .frame_first (frame_first),
    .init_ready  (init_ready),
    .pixel_next  (pixel_next),
    .spi_clk     (spi_clk),
    .spi_mosi    (spi_mosi),
    .spi_dc      (spi_dc)
  );

endmodule

//--- bench/spi_lcd_model.sv
`timescale 1ns/10ps

module spi_lcd_model #(
  parameter int CLK_PERIOD_NS = 4
) (
  input logic rst,
  input logic spi_clk,
  input logic spi_mosi,
  input logic spi_dc
);

  // Decoded traffic, one entry per byte
  logic [7:0] data_q  [$];
  logic       dc_q    [$];
  longint     stamp_q [$];  // Clock cycle of the last bit
  int         dc_changes;   // dc moved in the middle of a byte

  logic [7:0] shift;
  int         bit_cnt;
  logic       byte_dc;

  initial begin
    bit_cnt    = 0;
    dc_changes = 0;
  end

  // Mode 3, sampled on the rising edge, MSB first
  always @(posedge spi_clk) begin
    if (rst) begin
      bit_cnt = 0;
    end else begin
      if (bit_cnt == 0) begin
        byte_dc = spi_dc;
      end else if (spi_dc !== byte_dc) begin
        dc_changes++;
      end
      shift = {shift[6:0], spi_mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        data_q.push_back(shift);
        dc_q.push_back(byte_dc);
        stamp_q.push_back($time / CLK_PERIOD_NS);
        bit_cnt = 0;
      end
    end
  end

endmodule

//--- bench/st7789_tb.sv
`timescale 1ns/10ps

module st7789_tb
  import st7789_pkg::*;
();

  logic        clk_pixel;
  logic        rst;
  logic        spi_clk;
  logic        spi_mosi;
  logic        spi_dc;
  logic        spi_resn;
  int unsigned cycle;       // Clocks since reset release
  int          errors;
  int          timeouts;
  bit          timed_out;
  logic [9:0]  rom_copy [INIT_WORDS];

  initial begin
    clk_pixel = 1'b0;
    forever #2 clk_pixel = ~clk_pixel;  // 4 ns
  end

  always_ff @(posedge clk_pixel) begin
    if (rst) cycle <= 0;
    else cycle <= cycle + 1;
  end

  st7789_video_top dut_i (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .spi_clk   (spi_clk),
    .spi_mosi  (spi_mosi),
    .spi_dc    (spi_dc),
    .spi_resn  (spi_resn)
  );

  spi_lcd_model panel_i (
    .rst      (rst),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_dc   (spi_dc)
  );

  // Panel reset is low for the hold time after reset and high from then on
  resn_level: assert property (@(posedge clk_pixel) disable iff (rst)
      spi_resn === (cycle >= RESET_HOLD_CYCLES))
    else begin
      errors++;
      $display("FAIL reset_hold %0d: expected %b actual %b", $sampled(cycle),
               $sampled(cycle) >= RESET_HOLD_CYCLES, $sampled(spi_resn));
    end

  // spi_clk stays idle through reset hold and wait
  quiet_clk: assert property (@(posedge clk_pixel) disable iff (rst)
      (cycle <= RESET_HOLD_CYCLES + RESET_WAIT_CYCLES) |-> spi_clk)
    else begin
      errors++;
      $display("FAIL quiet_clk %0d: expected 1 actual %b", $sampled(cycle), $sampled(spi_clk));
    end

  task automatic check_equal(input string name, input int index,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected === actual) else begin
      errors++;
      $display("FAIL %s %0d: expected 0x%0h actual 0x%0h", name, index, expected, actual);
    end
  endtask

  task automatic wait_for_bytes(input int count, input int limit, input string what);
    int t;
    t = 0;
    while (panel_i.data_q.size() < count && t < limit) begin
      @(negedge clk_pixel);
      t++;
    end
    if (panel_i.data_q.size() < count) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout: %s not complete after %0d cycles, only %0d bytes seen",
               what, limit, panel_i.data_q.size());
    end
  endtask

  // Window header item k as {dc, byte}
  function automatic logic [8:0] header_item(input int k);
    case (k)
      0:       return {1'b0, CMD_CASET};
      5:       return {1'b0, CMD_RASET};
      10:      return {1'b0, CMD_RAMWR};
      4, 9:    return {1'b1, 8'hEF};      // End coordinate 239
      default: return {1'b1, 8'h00};
    endcase
  endfunction

  function automatic logic [15:0] bar_color(input int bar);
    case (bar)
      0:       return 16'hFFFF;  // White
      1:       return 16'hFFE0;  // Yellow
      2:       return 16'h07FF;
      3:       return 16'h07E0;
      4:       return 16'hF81F;
      5:       return 16'hF800;
      6:       return 16'h001F;
      default: return 16'h0000;  // Black
    endcase
  endfunction

  task automatic check_header(input int base, input string name);
    logic [8:0] exp;
    for (int k = 0; k < 11; k++) begin
      exp = header_item(k);
      check_equal({name, " byte"}, k, exp[7:0], panel_i.data_q[base + k]);
      check_equal({name, " dc"}, k, exp[8], panel_i.dc_q[base + k]);
    end
  endtask

  initial begin
    int          n_init;
    int          base;
    int          b;
    int          t;
    longint      gap;
    logic [15:0] exp_color;
    errors    = 0;
    timeouts  = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    $readmemh("st7789_init.mem", rom_copy);
    n_init = 0;
    for (int i = 0; i < INIT_WORDS; i++) begin
      if (!rom_copy[i][9]) n_init++;
    end
    base = n_init + 11;
    repeat (2) @(posedge clk_pixel);
    @(negedge clk_pixel);
    rst = 1'b0;

    begin : checks
      t = 0;
      while (spi_resn !== 1'b1 && t < 1000) begin
        @(negedge clk_pixel);
        t++;
      end
      if (spi_resn !== 1'b1) begin
        timeouts++;
        $display("Timeout: panel reset was never released");
        disable checks;
      end
      wait_for_bytes(base, 20000, "init bytes and first header");
      if (timed_out) disable checks;

      // Byte words in ROM order, delays only stretch the gaps
      b = 0;
      for (int i = 0; i < INIT_WORDS; i++) begin
        if (rom_copy[i][9]) begin
          gap = (b > 0) ? panel_i.stamp_q[b] - panel_i.stamp_q[b - 1] : 0;
          assert (b == 0 || gap >= rom_copy[i][7:0] * DELAY_UNIT_CYCLES) else begin
            errors++;
            $display("FAIL init delay %0d: expected at least %0d actual %0d",
                     i, rom_copy[i][7:0] * DELAY_UNIT_CYCLES, gap);
          end
        end else begin
          check_equal("init byte", b, rom_copy[i][7:0], panel_i.data_q[b]);
          check_equal("init dc", b, rom_copy[i][8], panel_i.dc_q[b]);
          b++;
        end
      end
      check_header(n_init, "first header");

      wait_for_bytes(base + 2 * PIXELS, 2 * PIXELS * 16 + 2000, "first frame pixels");
      if (timed_out) disable checks;
      for (int n = 0; n < PIXELS; n++) begin
        exp_color = bar_color((n % X_SIZE) / BAR_WIDTH);
        check_equal("pixel high", n, exp_color[15:8], panel_i.data_q[base + 2 * n]);
        check_equal("pixel low", n, exp_color[7:0], panel_i.data_q[base + 2 * n + 1]);
        check_equal("pixel high dc", n, 1'b1, panel_i.dc_q[base + 2 * n]);
        check_equal("pixel low dc", n, 1'b1, panel_i.dc_q[base + 2 * n + 1]);
      end
      for (int k = n_init + 1; k < base + 2 * PIXELS; k++) begin
        gap = panel_i.stamp_q[k] - panel_i.stamp_q[k - 1];
        check_equal("byte gap", k, 16, gap);
      end

      wait_for_bytes(base + 2 * PIXELS + 11, 1000, "second header");
      if (timed_out) disable checks;
      check_header(base + 2 * PIXELS, "second header");
      check_equal("dc changes", 0, 0, panel_i.dc_changes);
    end

    $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- st7789_init.mem
// Bit 9 marks a delay word, bit 8 is dc, bits 7:0 are the byte
// For a delay word, bits 7:0 are the count in units of DELAY_UNIT_CYCLES
001  // SWRESET
202
011  // SLPOUT
202
03A  // COLMOD, 16 bits per pixel
155
036  // MADCTL
100
0B2  // PORCTRL
10C
10C
100
133
133
0B7  // GCTRL
135
021  // INVON
013  // NORON
029  // DISPON
201

//--- vlog.f
src/st7789_pkg.sv
src/pattern_gen.sv
src/lcd_init_seq.sv
src/lcd_spi_out.sv
src/st7789_video_top.sv
bench/spi_lcd_model.sv
bench/st7789_tb.sv

//--- Bender.yml
package:
  name: st7789_video

sources:
  # Design, package first
  - src/st7789_pkg.sv
  - src/pattern_gen.sv
  - src/lcd_init_seq.sv
  - src/lcd_spi_out.sv
  - src/st7789_video_top.sv

  # Testbench
  - target: test
    files:
      - bench/spi_lcd_model.sv
      - bench/st7789_tb.sv
